/* hdl/nest4_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-level nested counter
// cnt0 is innermost; each outer count steps when all inner counts wrap.
// last flags the final step of the whole nest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module nest4_counter #(
    parameter int n0_max = 3,               // Count range of cnt0
    parameter int n1_max = 3,               // Count range of cnt1
    parameter int n2_max = 2,               // Count range of cnt2
    parameter int n3_max = 2                // Count range of cnt3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  logic                    ena,
    output weight_load_pkg::chan_t  cnt0,
    output weight_load_pkg::chan_t  cnt1,
    output weight_load_pkg::chan_t  cnt2,
    output weight_load_pkg::chan_t  cnt3,
    output logic                    last
);

    logic wrap0;                            // cnt0 at its top value
    logic wrap1;
    logic wrap2;
    logic wrap3;

    assign wrap0 = (cnt0 == weight_load_pkg::chan_t'(n0_max - 1));
    assign wrap1 = (cnt1 == weight_load_pkg::chan_t'(n1_max - 1));
    assign wrap2 = (cnt2 == weight_load_pkg::chan_t'(n2_max - 1));
    assign wrap3 = (cnt3 == weight_load_pkg::chan_t'(n3_max - 1));

    // All four at their top, so an enabled step now is the final one
    assign last = wrap0 && wrap1 && wrap2 && wrap3;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt0 <= '0;
            cnt1 <= '0;
            cnt2 <= '0;
            cnt3 <= '0;
        end else if (clear) begin
            cnt0 <= '0;                     // Clear overrides an enabled step
            cnt1 <= '0;
            cnt2 <= '0;
            cnt3 <= '0;
        end else if (ena) begin
            cnt0 <= wrap0 ? '0 : cnt0 + 1'b1;
            if (wrap0) begin
                cnt1 <= wrap1 ? '0 : cnt1 + 1'b1;
            end
            if (wrap0 && wrap1) begin
                cnt2 <= wrap2 ? '0 : cnt2 + 1'b1;
            end
            if (wrap0 && wrap1 && wrap2) begin
                cnt3 <= wrap3 ? '0 : cnt3 + 1'b1;   // Whole nest rolls over after last
            end
        end
    end

endmodule

/* hdl/sig_delay.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe delay line
// Delays a one-bit signal by a fixed number of clock cycles, cleared on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sig_delay #(
    parameter int depth = 3                 // Delay in cycles, one or more
) (
    input  logic clk,
    input  logic rst,
    input  logic sig_in,
    output logic sig_out
);

    logic [depth-1:0] stage;                // Stage 0 takes the input, last stage drives out

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= '0;                    // No strobe survives a reset
        end else begin
            stage[0] <= sig_in;
            for (int k = 1; k < depth; k++) begin
                stage[k] <= stage[k-1];     // Shift one stage per cycle
            end
        end
    end

    assign sig_out = stage[depth-1];

endmodule

/* hdl/weight_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight FIFO
// Synchronous circular buffer with first-word-fall-through output and an
// almost-full flag that keeps room for pushes already in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module weight_fifo #(
    parameter int depth    = 16,            // Number of entries
    parameter int af_slack = 3              // almost_full when free slots <= this
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  weight_load_pkg::weight_t    push_data,
    output logic                        almost_full,
    input  logic                        pop,
    output weight_load_pkg::weight_t    pop_data,
    output logic                        empty
);

    localparam int pw = $clog2(depth);      // Pointer width
    localparam int cw = $clog2(depth + 1);  // Count width, holds depth itself

    weight_load_pkg::weight_t mem [0:depth-1];
    logic [pw-1:0] wr_ptr;
    logic [pw-1:0] rd_ptr;
    logic [cw-1:0] count;                   // Words currently stored
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full        = (count == cw'(depth));
    assign empty       = (count == '0);
    assign almost_full = (cw'(depth) - count) <= cw'(af_slack);
    assign wr_en       = push && !full;     // Loader respects almost_full, so no drop
    assign rd_en       = pop && !empty;
    assign pop_data    = mem[rd_ptr];       // Head word, valid while not empty

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hdl/weight_load_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight load types
// Weight word, RAM address, channel index, tile base and RAM write bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "weight_load_params.svh"

package weight_load_pkg;

    typedef logic [`WL_DW-1:0] weight_t;    // One weight word
    typedef logic [`WL_AW-1:0] ram_addr_t;  // Weight RAM word address
    typedef logic [`WL_CW-1:0] chan_t;      // Channel number or loop index

    // First input and output channel of a tile
    typedef struct packed {
        chan_t base_n;                      // First input channel
        chan_t base_m;                      // First output channel
    } tile_base_t;

    // One RAM write, taken at the clock edge when en is high
    typedef struct packed {
        logic      en;                      // Write strobe
        ram_addr_t addr;                    // Target word
        weight_t   data;                    // Value to store
    } ram_wr_t;

endpackage

/* hdl/weight_load_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight load subsystem
// Weight RAM feeding the tile loader, which fills the weight FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "weight_load_params.svh"

module weight_load_top (
    input  logic                            clk,
    input  logic                            rst,
    input  weight_load_pkg::ram_wr_t        ram_wr,
    input  logic                            req,
    input  weight_load_pkg::tile_base_t     tile,
    output logic                            ack,
    input  logic                            pop,
    output weight_load_pkg::weight_t        pop_data,
    output logic                            empty
);

    weight_load_pkg::ram_addr_t rd_addr;    // Loader to RAM
    weight_load_pkg::weight_t   rd_data;    // RAM to loader, two cycles later
    logic                       push;
    weight_load_pkg::weight_t   push_data;
    logic                       almost_full;

    weight_ram u_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    weight_tile_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .tile        (tile),
        .ack         (ack),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .push        (push),
        .push_data   (push_data),
        .almost_full (almost_full)
    );

    weight_fifo #(
        .depth    (`WL_FIFO_DEPTH),
        .af_slack (`WL_FIFO_AF_SLACK)       // Covers the three pushes in flight
    ) u_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (push),
        .push_data   (push_data),
        .almost_full (almost_full),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty)
    );

endmodule

/* hdl/weight_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight RAM
// Holds the full weight tensor; one write port and one read port with a
// fixed two-cycle read latency (registered address, registered data)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "weight_load_params.svh"

module weight_ram (
    input  logic                        clk,
    input  weight_load_pkg::ram_wr_t    wr,
    input  weight_load_pkg::ram_addr_t  rd_addr,
    output weight_load_pkg::weight_t    rd_data
);

    localparam int words = `WL_N * `WL_M * `WL_K * `WL_K;  // One word per weight

    weight_load_pkg::weight_t   mem [0:words-1];
    weight_load_pkg::ram_addr_t rd_addr_q;                 // First latency stage

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;        // Write lands at this edge
        end
    end

    // The address register and then the output register give two stages
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];        // Words past the tensor end are never used
    end

endmodule

/* hdl/weight_tile_loader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight tile loader
// On a req, walks one Tn x Tm x K x K weight tile in row-major order, reads
// each weight from RAM and pushes it into the weight FIFO. Positions past
// the tensor edge are pushed as zero. ack closes the four-phase handshake
// once the last weight of the tile is in the FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "weight_load_params.svh"

module weight_tile_loader (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  weight_load_pkg::tile_base_t     tile,
    output logic                            ack,
    output weight_load_pkg::ram_addr_t      rd_addr,
    input  weight_load_pkg::weight_t        rd_data,
    output logic                            push,
    output weight_load_pkg::weight_t        push_data,
    input  logic                            almost_full
);

    localparam int mkk    = `WL_M * `WL_K * `WL_K;  // Stride of one input channel
    localparam int kk     = `WL_K * `WL_K;          // Stride of one output channel
    localparam int full_w = 16;                     // Address arithmetic width
    localparam int issue_to_push = `WL_RAM_LAT + 1; // RAM latency plus output register

    weight_load_pkg::tile_base_t tile_q;            // Base latched at the request
    weight_load_pkg::chan_t      cnt_j;             // Kernel column, innermost
    weight_load_pkg::chan_t      cnt_i;             // Kernel row
    weight_load_pkg::chan_t      cnt_tm;            // Output channel offset in the tile
    weight_load_pkg::chan_t      cnt_tn;            // Input channel offset, outermost

    logic              running;                     // Tile walk in progress
    logic [1:0]        drain_cnt;                   // Cycles until the final push has gone
    logic              start;
    logic              issue;                       // An address goes out this cycle
    logic              last;                        // Current step is the tile's final one
    logic              in_range;                    // Issued position lies inside the tensor
    logic              data_ok;                     // in_range, aligned with rd_data
    logic [`WL_CW:0]   chan_n;                      // Absolute input channel, one spare bit
    logic [`WL_CW:0]   chan_m;                      // Absolute output channel
    logic [full_w-1:0] addr_full;

    // Idle means no walk, no drain and the previous handshake fully closed
    assign start = req && !running && !ack && (drain_cnt == 2'd0);
    assign issue = running && !almost_full;         // Counter holds under back-pressure

    nest4_counter #(
        .n0_max (`WL_K),
        .n1_max (`WL_K),
        .n2_max (`WL_TM),
        .n3_max (`WL_TN)
    ) u_counter (
        .clk   (clk),
        .rst   (rst),
        .clear (start),                             // Every tile starts from zero
        .ena   (issue),
        .cnt0  (cnt_j),
        .cnt1  (cnt_i),
        .cnt2  (cnt_tm),
        .cnt3  (cnt_tn),
        .last  (last)
    );

    assign chan_n = {1'b0, tile_q.base_n} + {1'b0, cnt_tn};
    assign chan_m = {1'b0, tile_q.base_m} + {1'b0, cnt_tm};

    // Row-major order with the input channel outermost and the kernel column innermost
    assign addr_full = full_w'(chan_n) * full_w'(mkk)
                     + full_w'(chan_m) * full_w'(kk)
                     + full_w'(cnt_i) * full_w'(`WL_K)
                     + full_w'(cnt_j);

    assign rd_addr  = addr_full[`WL_AW-1:0];        // Out-of-range words are masked later
    assign in_range = (chan_n < `WL_N) && (chan_m < `WL_M);

    sig_delay #(
        .depth (issue_to_push)
    ) u_push_dly (
        .clk     (clk),
        .rst     (rst),
        .sig_in  (issue),
        .sig_out (push)                             // Push lands three cycles after issue
    );

    sig_delay #(
        .depth (`WL_RAM_LAT)
    ) u_range_dly (
        .clk     (clk),
        .rst     (rst),
        .sig_in  (in_range),
        .sig_out (data_ok)                          // Travels alongside the RAM data
    );

    // Output register stage, zero for positions past the tensor edge
    always_ff @(posedge clk) begin
        push_data <= data_ok ? rd_data : '0;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tile_q <= tile;                         // Requester keeps tile stable until ack
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            drain_cnt <= 2'd0;
            ack       <= 1'b0;
        end else begin
            if (start) begin
                running <= 1'b1;
            end else if (issue && last) begin
                running   <= 1'b0;                  // Final address issued
                drain_cnt <= 2'(issue_to_push);     // Wait out the pushes still in flight
            end else if (drain_cnt != 2'd0) begin
                drain_cnt <= drain_cnt - 2'd1;
            end

            // Count of one means the final push is on the bus this cycle
            if (drain_cnt == 2'd1) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;                        // Requester has dropped req
            end
        end
    end

endmodule

/* include/weight_load_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight load path parameters
// Tensor dimensions, tile sizes, data and address widths, RAM read latency
// and FIFO sizing shared by the weight-loading blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WEIGHT_LOAD_PARAMS_SVH
`define WEIGHT_LOAD_PARAMS_SVH

// Tensor dimensions
`define WL_N 5              // Input channels, chosen so that tiles overrun the edge
`define WL_M 3              // Output channels
`define WL_K 3              // Kernel size, K x K positions per channel pair

// Tile sizes
`define WL_TN 2             // Input channels per tile
`define WL_TM 2             // Output channels per tile

// Widths
`define WL_DW 16            // Weight word width
`define WL_AW 8             // RAM address width, covers N*M*K*K = 135 words
`define WL_CW 8             // Loop counter and channel index width

// RAM read latency in cycles from address to data
`define WL_RAM_LAT 2

// FIFO sizing
`define WL_FIFO_DEPTH 16
`define WL_FIFO_AF_SLACK 3  // Free slots held back for pushes still in flight

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the weight load testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_weight_load -Mdir obj_dir

./obj_dir/Vtb_weight_load | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Weight load run passed"
else
    echo "Weight load run failed, see sim.log"
    exit 1
fi

/* src.f */
+incdir+include
hdl/weight_load_pkg.sv
hdl/sig_delay.sv
hdl/nest4_counter.sv
hdl/weight_ram.sv
hdl/weight_tile_loader.sv
hdl/weight_fifo.sv
hdl/weight_load_top.sv
verification/tb_weight_load.sv

/* verification/tb_weight_load.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Weight load subsystem testbench
// Fills the weight RAM, requests five tiles over the four-phase handshake,
// drains the FIFO with random stalls and checks every word and ack level
// against a reference model of the row-major tile walk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "weight_load_params.svh"

module tb_weight_load;

    localparam int ram_words  = `WL_N * `WL_M * `WL_K * `WL_K;
    localparam int tile_words = `WL_TN * `WL_TM * `WL_K * `WL_K;
    // RAM fill of 135 cycles plus five tiles of 36 words; at an 85 percent
    // pop stall a tile takes roughly 250 cycles, so 4000 leaves a wide margin
    localparam int timeout_cycles = 4000;

    logic                           clk = 1'b0;
    logic                           rst;
    weight_load_pkg::ram_wr_t       ram_wr;
    logic                           req;
    weight_load_pkg::tile_base_t    tile;
    logic                           ack;
    logic                           pop = 1'b0;     // Driven by the drain process only
    weight_load_pkg::weight_t       pop_data;
    logic                           empty;

    weight_load_pkg::weight_t exp_q [$];            // Every expected word, in issue order
    int got_count = 0;                              // Words popped and checked so far
    int stall_pct = 0;                              // Chance in percent of skipping a pop
    int cycle_cnt = 0;
    logic ack_q = 1'b0;                             // ack as seen one cycle earlier

    weight_load_top u_weight_load_top (
        .clk      (clk),
        .rst      (rst),
        .ram_wr   (ram_wr),
        .req      (req),
        .tile     (tile),
        .ack      (ack),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty)
    );

    always #2 clk = ~clk;                           // 4 ns period

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_weight(input string name, input weight_load_pkg::weight_t exp_val,
                                input weight_load_pkg::weight_t act_val);
        if (act_val !== exp_val) begin
            $display("ERROR at %0d ns: %s expected 0x%h, got 0x%h",
                     $time, name, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_ack(input logic exp_val);
        if (ack !== exp_val) begin
            $display("ERROR at %0d ns: ack expected %b, got %b", $time, exp_val, ack);
            abort_run();
        end
    endtask

    // RAM contents; the high byte is never zero, so masked words stand out
    function automatic weight_load_pkg::weight_t pattern(input int addr);
        logic [7:0] a;
        a = addr[7:0];
        return {a ^ 8'hC3, a * 8'd7 + 8'd1};
    endfunction

    // Row-major address of the weight, or zero past the tensor edge
    function automatic weight_load_pkg::weight_t expected_weight(
        input weight_load_pkg::tile_base_t base, input int tn, input int tm,
        input int i, input int j);
        int n;
        int m;
        n = int'(base.base_n) + tn;
        m = int'(base.base_m) + tm;
        if (n >= `WL_N || m >= `WL_M) begin
            return '0;
        end
        return pattern(n * `WL_M * `WL_K * `WL_K + m * `WL_K * `WL_K + i * `WL_K + j);
    endfunction

    // Drain and compare; pops every cycle once ack is up so the tile completes
    always @(posedge clk) begin
        #1;
        pop = 1'b0;
        if (!rst) begin
            if (ack && empty && got_count < exp_q.size()) begin
                report_error("ack is high but words of the tile never reached the FIFO");
            end
            // Without stalls the FIFO holds at most one word, so the last word
            // of the tile sits at the head in the cycle ack rises
            if (ack && !ack_q && stall_pct == 0
                    && got_count + (empty ? 0 : 1) != exp_q.size()) begin
                report_error("ack rose before the last word of the tile entered the FIFO");
            end
            if (!empty) begin
                if (got_count >= exp_q.size()) begin
                    report_error("FIFO holds a word that no tile request accounts for");
                end
                if (ack || int'($urandom % 100) >= stall_pct) begin
                    check_weight("pop_data", exp_q[got_count], pop_data);
                    got_count++;
                    pop = 1'b1;
                end
            end
        end
        ack_q = ack;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            report_error("Timeout: the tile loads did not finish in the allowed cycles");
        end
    end

    task automatic load_tile(input weight_load_pkg::tile_base_t base, input int stall);
        for (int tn = 0; tn < `WL_TN; tn++) begin
            for (int tm = 0; tm < `WL_TM; tm++) begin
                for (int i = 0; i < `WL_K; i++) begin
                    for (int j = 0; j < `WL_K; j++) begin
                        exp_q.push_back(expected_weight(base, tn, tm, i, j));
                    end
                end
            end
        end
        stall_pct = stall;
        tile = base;
        req  = 1'b1;
        @(posedge clk);
        #1;
        check_ack(1'b0);                            // A tile can't finish in one cycle
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        while (got_count < exp_q.size()) begin
            @(posedge clk);
            #1;
            check_ack(1'b1);                        // Held until req drops
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        check_ack(1'b0);                            // Falls one cycle after req low
        tile = '1;                                  // Loader must have latched the base
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        if (got_count != exp_q.size()) begin
            report_error("Word count of the tile differs from 36");
        end
    endtask

    initial begin
        void'($urandom(5));
        rst    = 1'b1;
        ram_wr = '0;
        req    = 1'b0;
        tile   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_ack(1'b0);
        if (!empty) begin
            report_error("FIFO is not empty after reset");
        end
        // Drain flags any word that shows up before the first request
        for (int a = 0; a < ram_words; a++) begin
            ram_wr.en   = 1'b1;
            ram_wr.addr = weight_load_pkg::ram_addr_t'(a);
            ram_wr.data = pattern(a);
            @(posedge clk);
            #1;
        end
        ram_wr.en = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        load_tile('{base_n: 8'd0, base_m: 8'd0}, 0);    // Fully in range
        load_tile('{base_n: 8'd4, base_m: 8'd2}, 0);    // Overruns both edges
        load_tile('{base_n: 8'd2, base_m: 8'd0}, 85);   // FIFO fills, back-pressure
        load_tile('{base_n: 8'd4, base_m: 8'd1}, 60);
        load_tile('{base_n: 8'd1, base_m: 8'd1}, 30);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
